//--- src/pattern_pkg.sv
package pattern_pkg;

    // four keys or four switches
    typedef logic [3:0] key_t;

    // led bank, also the shift register contents
    typedef logic [7:0] led_t;

    typedef logic [7:0] strobe_count_t;

    // wraps at 16
    typedef logic [3:0] hit_count_t;

    typedef enum logic [1:0] {
        moore_idle,
        moore_got_1,
        moore_got_10,
        moore_found
    } moore_state_t;

    typedef enum logic [1:0] {
        mealy_idle,
        mealy_got_1,
        mealy_got_10
    } mealy_state_t;

    typedef struct packed {
        logic       hit;
        hit_count_t count;
    } detector_status_t;

endpackage

//--- src/display_pkg.sv
package display_pkg;

    // abcdefg then dot in bit 0, all active low
    typedef logic [7:0] segments_t;

    // one-hot digit select, active low
    typedef logic [7:0] anodes_t;

    // eight nibbles, digit 0 in the lowest one
    typedef logic [31:0] display_number_t;

    typedef struct packed {
        display_number_t number;
        logic [7:0]      dots;
    } display_data_t;

    // nibble to active-low abcdefg
    function automatic logic [6:0] hex_font(input logic [3:0] nibble);
        logic [6:0] lit;
        case (nibble)
            4'h0: lit = 7'b1111110;
            4'h1: lit = 7'b0110000;
            4'h2: lit = 7'b1101101;
            4'h3: lit = 7'b1111001;
            4'h4: lit = 7'b0110011;
            4'h5: lit = 7'b1011011;
            4'h6: lit = 7'b1011111;
            4'h7: lit = 7'b1110000;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1111011;
            4'ha: lit = 7'b1110111;
            4'hb: lit = 7'b0011111;
            4'hc: lit = 7'b1001110;
            4'hd: lit = 7'b0111101;
            4'he: lit = 7'b1001111;
            default: lit = 7'b1000111;
        endcase
        return ~lit;
    endfunction

endpackage

//--- src/sync_and_debounce.sv
`timescale 1ns/1ps

module sync_and_debounce #(
    parameter int w     = 8,
    parameter int depth = 8
) (
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic [w-1:0] i_in,
    output logic [w-1:0] o_out
);

    logic [w-1:0]     sync_0;
    logic [w-1:0]     sync_1;
    logic [w-1:0]     last;
    logic [depth-1:0] stable_cnt;

    // two-flop synchronizer
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_0 <= '0;
            sync_1 <= '0;
        end else begin
            sync_0 <= i_in;
            sync_1 <= sync_0;
        end
    end

    // any change restarts the stability count
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last       <= '0;
            stable_cnt <= '0;
            o_out      <= '0;
        end else if (sync_1 != last) begin
            last       <= sync_1;
            stable_cnt <= '0;
        end else if (stable_cnt != '1) begin
            stable_cnt <= stable_cnt + 1'b1;
        end else begin
            // stable for 2^depth cycles
            o_out <= last;
        end
    end

endmodule

//--- src/strobe_gen.sv
`timescale 1ns/1ps

module strobe_gen #(
    parameter int w = 8
) (
    input  logic clk,
    input  logic i_rst_n,
    output logic o_strobe
);

    logic [w-1:0] cnt;

    // free running, wraps every 2^w cycles
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // one cycle wide, at the all-ones count
    assign o_strobe = (cnt == '1);

endmodule

//--- src/bit_shifter.sv
`timescale 1ns/1ps

module bit_shifter (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_en,
    input  logic                      i_in,
    output pattern_pkg::led_t          o_bits,
    output pattern_pkg::strobe_count_t o_strobe_count
);

    pattern_pkg::led_t          bits;
    pattern_pkg::strobe_count_t strobe_count;

    // new bit enters at bit 0, older bits move up
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bits <= '0;
        end else if (i_en) begin
            bits <= {bits[6:0], i_in};
        end
    end

    // counts every strobe that moved the register
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            strobe_count <= '0;
        end else if (i_en) begin
            strobe_count <= strobe_count + 1'b1;
        end
    end

    assign o_bits         = bits;
    assign o_strobe_count = strobe_count;

endmodule

//--- src/moore_fsm.sv
`timescale 1ns/1ps

module moore_fsm (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_en,
    input  logic                         i_a,
    output pattern_pkg::detector_status_t o_status
);

    pattern_pkg::moore_state_t state;
    pattern_pkg::moore_state_t state_next;
    pattern_pkg::hit_count_t   hit_count;
    logic                      hit;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= pattern_pkg::moore_idle;
        end else if (i_en) begin
            state <= state_next;
        end
    end

    // found behaves like got_1 since the last 1 starts a new pattern
    always_comb begin
        state_next = state;
        case (state)
            pattern_pkg::moore_idle:
                state_next = i_a ? pattern_pkg::moore_got_1 : pattern_pkg::moore_idle;
            pattern_pkg::moore_got_1:
                state_next = i_a ? pattern_pkg::moore_got_1 : pattern_pkg::moore_got_10;
            pattern_pkg::moore_got_10:
                state_next = i_a ? pattern_pkg::moore_found : pattern_pkg::moore_idle;
            pattern_pkg::moore_found:
                state_next = i_a ? pattern_pkg::moore_got_1 : pattern_pkg::moore_got_10;
            default:
                state_next = pattern_pkg::moore_idle;
        endcase
    end

    // output from the state alone
    assign hit = (state == pattern_pkg::moore_found);

    // counts one strobe after the pattern completes
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hit_count <= '0;
        end else if (i_en && hit) begin
            hit_count <= hit_count + 1'b1;
        end
    end

    assign o_status = '{hit: hit, count: hit_count};

endmodule

//--- src/mealy_fsm.sv
`timescale 1ns/1ps

module mealy_fsm (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_en,
    input  logic                         i_a,
    output pattern_pkg::detector_status_t o_status
);

    pattern_pkg::mealy_state_t state;
    pattern_pkg::mealy_state_t state_next;
    pattern_pkg::hit_count_t   hit_count;
    logic                      hit;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= pattern_pkg::mealy_idle;
        end else if (i_en) begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            pattern_pkg::mealy_idle:
                state_next = i_a ? pattern_pkg::mealy_got_1 : pattern_pkg::mealy_idle;
            pattern_pkg::mealy_got_1:
                state_next = i_a ? pattern_pkg::mealy_got_1 : pattern_pkg::mealy_got_10;
            // a hit leaves us in got_1, the patterns overlap
            pattern_pkg::mealy_got_10:
                state_next = i_a ? pattern_pkg::mealy_got_1 : pattern_pkg::mealy_idle;
            default:
                state_next = pattern_pkg::mealy_idle;
        endcase
    end

    // output depends on the input too
    assign hit = (state == pattern_pkg::mealy_got_10) && i_a;

    // counts on the strobe that sees the third bit
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hit_count <= '0;
        end else if (i_en && hit) begin
            hit_count <= hit_count + 1'b1;
        end
    end

    assign o_status = '{hit: hit, count: hit_count};

endmodule

//--- src/seven_segment.sv
`timescale 1ns/1ps

module seven_segment (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_en,
    input  display_pkg::display_data_t i_data,
    output display_pkg::segments_t     o_segments,
    output display_pkg::anodes_t       o_anodes
);

    logic [2:0] digit_index;
    logic       en_q;
    logic [3:0] nibble;
    logic       dot;

    // next digit on every scan strobe
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            digit_index <= '0;
        end else if (i_en) begin
            digit_index <= digit_index + 1'b1;
        end
    end

    // outputs load one cycle after the strobe
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= i_en;
        end
    end

    // pick the nibble and dot for the current digit
    assign nibble = i_data.number[{digit_index, 2'b00} +: 4];
    assign dot    = i_data.dots[digit_index];

    // all digits dark until the first strobe
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_anodes   <= '1;
            o_segments <= '1;
        end else if (en_q) begin
            o_anodes   <= ~(display_pkg::anodes_t'(1) << digit_index);
            // dot pin is active low
            o_segments <= {display_pkg::hex_font(nibble), ~dot};
        end
    end

endmodule

//--- src/top.sv
`timescale 1ns/1ps

module top #(
    parameter int debounce_depth             = 8,
    parameter int shift_strobe_width         = 23,
    parameter int seven_segment_strobe_width = 10
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  pattern_pkg::key_t      i_key,
    input  pattern_pkg::key_t      i_sw,
    output pattern_pkg::led_t      o_led,
    output display_pkg::segments_t o_abcdefgh,
    output display_pkg::anodes_t   o_digit
);

    pattern_pkg::key_t            key_db;
    pattern_pkg::key_t            sw_db;
    logic                         shift_tick;
    logic                         scan_tick;
    pattern_pkg::led_t            shift_bits;
    pattern_pkg::strobe_count_t   strobe_count;
    pattern_pkg::detector_status_t moore_status;
    pattern_pkg::detector_status_t mealy_status;
    display_pkg::display_data_t   disp_data;

    // board pins are active low
    sync_and_debounce #(.w(8), .depth(debounce_depth)) debounce (
        .clk    (clk),
        .i_rst_n(i_rst_n),
        .i_in   (~{i_key, i_sw}),
        .o_out  ({key_db, sw_db})
    );

    strobe_gen #(.w(shift_strobe_width)) shift_strobe (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .o_strobe(shift_tick)
    );

    // key 2 is the serial data bit
    bit_shifter shifter (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_en          (shift_tick),
        .i_in          (key_db[2]),
        .o_bits        (shift_bits),
        .o_strobe_count(strobe_count)
    );

    // leds light on low
    assign o_led = ~shift_bits;

    moore_fsm moore_detector (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_en    (shift_tick),
        .i_a     (shift_bits[0]),
        .o_status(moore_status)
    );

    mealy_fsm mealy_detector (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_en    (shift_tick),
        .i_a     (shift_bits[0]),
        .o_status(mealy_status)
    );

    // mealy count on the rightmost digit
    assign disp_data = '{
        number: {16'b0, strobe_count, moore_status.count, mealy_status.count},
        dots:   {sw_db, key_db}
    };

    strobe_gen #(.w(seven_segment_strobe_width)) scan_strobe (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .o_strobe(scan_tick)
    );

    seven_segment display (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_en      (scan_tick),
        .i_data    (disp_data),
        .o_segments(o_abcdefgh),
        .o_anodes  (o_digit)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 2
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(half_period) o_clk = ~o_clk;
        end
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge o_clk);
        #(half_period) o_rst_n = 1'b1;
    end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int clock_period_ns = 10;
    localparam int shift_period    = 64;
    localparam int scan_period     = 4;
    localparam int half_period     = 32;
    // two sync flops plus four stable cycles plus the output flop
    localparam int debounce_delay  = 7;
    localparam int run_periods     = 250;
    localparam int limit_periods   = 300;

    logic                       clk;
    logic                       rst_n;
    pattern_pkg::key_t          key_pins;
    pattern_pkg::key_t          sw_pins;
    pattern_pkg::led_t          led;
    display_pkg::segments_t     segs;
    display_pkg::anodes_t       digit;

    logic [31:0]                rng_state;
    pattern_pkg::key_t          key_chosen;
    pattern_pkg::key_t          sw_chosen;
    pattern_pkg::key_t          key_level;
    pattern_pkg::key_t          sw_level;
    pattern_pkg::led_t          model_shift;
    pattern_pkg::strobe_count_t model_strobes;
    pattern_pkg::hit_count_t    model_mealy;
    pattern_pkg::hit_count_t    model_moore;
    logic [1:0]                 last_two;
    logic                       moore_in_found;
    int                         scan_index;
    int                         exp_index;
    display_pkg::anodes_t       exp_digit;
    display_pkg::segments_t     exp_segs;
    int                         cycle;
    int                         offset;

    tb_clock clock_gen (
        .o_clk  (clk),
        .o_rst_n(rst_n)
    );

    top #(
        .debounce_depth            (2),
        .shift_strobe_width        (6),
        .seven_segment_strobe_width(2)
    ) UUT (
        .clk       (clk),
        .i_rst_n   (rst_n),
        .i_key     (key_pins),
        .i_sw      (sw_pins),
        .o_led     (led),
        .o_abcdefgh(segs),
        .o_digit   (digit)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_led(input pattern_pkg::led_t actual, input pattern_pkg::led_t expected);
        if (actual !== expected) begin
            $display("error at %0t ns: o_led is %b, expected %b", $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_digit(input display_pkg::anodes_t actual,
                               input display_pkg::anodes_t expected);
        if (actual !== expected) begin
            $display("error at %0t ns: o_digit is %b, expected %b", $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_segments(input display_pkg::segments_t actual,
                                  input display_pkg::segments_t expected, input int index);
        if (actual !== expected) begin
            $display("error at %0t ns: o_abcdefgh for digit %0d is %b, expected %b",
                     $time, index, actual, expected);
            abort_run();
        end
    endtask

    // abcdefg for each hex digit, a zero lights the segment
    function automatic logic [6:0] segment_code(input logic [3:0] value);
        logic [6:0] code;
        case (value)
            4'h0: code = 7'b0000001;
            4'h1: code = 7'b1001111;
            4'h2: code = 7'b0010010;
            4'h3: code = 7'b0000110;
            4'h4: code = 7'b1001100;
            4'h5: code = 7'b0100100;
            4'h6: code = 7'b0100000;
            4'h7: code = 7'b0001111;
            4'h8: code = 7'b0000000;
            4'h9: code = 7'b0000100;
            4'ha: code = 7'b0001000;
            4'hb: code = 7'b1100000;
            4'hc: code = 7'b0110001;
            4'hd: code = 7'b1000010;
            4'he: code = 7'b0110000;
            default: code = 7'b0111000;
        endcase
        return code;
    endfunction

    // segments a digit should show from the model counts and levels
    function automatic display_pkg::segments_t digit_pattern(input int index);
        logic [3:0] nibble;
        logic       dot;
        case (index)
            0: nibble = model_mealy;
            1: nibble = model_moore;
            2: nibble = model_strobes[3:0];
            3: nibble = model_strobes[7:4];
            default: nibble = 4'h0;
        endcase
        dot = (index < 4) ? key_level[index] : sw_level[index - 4];
        return {segment_code(nibble), ~dot};
    endfunction

    // detectors see the bit shifted in on the previous strobe
    task automatic step_model();
        logic [2:0] recent;
        recent = {last_two, model_shift[0]};
        if (moore_in_found) begin
            model_moore = model_moore + 1'b1;
        end
        if (recent == 3'b101) begin
            model_mealy = model_mealy + 1'b1;
        end
        moore_in_found = (recent == 3'b101);
        last_two       = recent[1:0];
        model_shift    = {model_shift[6:0], key_level[2]};
        model_strobes  = model_strobes + 1'b1;
    endtask

    task automatic load_expected_display();
        exp_index            = scan_index % 8;
        exp_digit            = '1;
        exp_digit[exp_index] = 1'b0;
        exp_segs             = digit_pattern(exp_index);
    endtask

    // levels are the pressed state and the pins are active low
    task automatic pick_inputs();
        rng_state  = xorshift32(rng_state);
        key_chosen = rng_state[3:0];
        sw_chosen  = rng_state[11:8];
        key_pins   = ~key_chosen;
        sw_pins    = ~sw_chosen;
    endtask

    initial begin
        key_pins       = '1;
        sw_pins        = '1;
        rng_state      = 32'd51;
        key_chosen     = '0;
        sw_chosen      = '0;
        key_level      = '0;
        sw_level       = '0;
        model_shift    = '0;
        model_strobes  = '0;
        model_mealy    = '0;
        model_moore    = '0;
        last_two       = '0;
        moore_in_found = 1'b0;
        scan_index     = 0;
        exp_index      = 0;
        exp_digit      = '1;
        exp_segs       = '1;
        cycle          = 0;

        // everything dark while in reset
        #12;
        check_led(led, '1);
        check_digit(digit, '1);
        check_segments(segs, '1, 0);

        @(posedge rst_n);
        while (cycle < run_periods * shift_period) begin
            @(posedge clk);
            #1;
            cycle  = cycle + 1;
            offset = cycle % shift_period;
            if (offset == 0) begin
                step_model();
            end
            if (offset == half_period + debounce_delay) begin
                key_level = key_chosen;
                sw_level  = sw_chosen;
            end
            if (cycle % scan_period == 0) begin
                scan_index = scan_index + 1;
            end
            // display registers one cycle after the scan strobe
            if (cycle % scan_period == 1 && cycle > scan_period) begin
                load_expected_display();
            end
            if (offset == 8) begin
                check_led(led, ~model_shift);
            end
            if (offset >= 8 && offset <= 48) begin
                check_digit(digit, exp_digit);
                check_segments(segs, exp_segs, exp_index);
            end
            if (offset == half_period) begin
                pick_inputs();
            end
        end
        $display("Everything OK");
        $finish;
    end

    initial begin
        #(limit_periods * shift_period * clock_period_ns);
        $display("timeout: the run did not end within %0d shift periods", limit_periods);
        abort_run();
    end

endmodule

//--- compile.f
src/pattern_pkg.sv
src/display_pkg.sv
src/sync_and_debounce.sv
src/strobe_gen.sv
src/bit_shifter.sv
src/moore_fsm.sv
src/mealy_fsm.sv
src/seven_segment.sv
src/top.sv
tests/tb_clock.sv
tests/tb_top.sv
